// ==== hw/apb_iob_pkg.sv ====
package apb_iob_pkg;

   // Bus geometry
   localparam int ADDR_W  = 12;  // Byte address
   localparam int DATA_W  = 32;
   localparam int WSTRB_W = DATA_W / 8;

   // Value returned by the identity register
   localparam logic [DATA_W-1:0] ID_VALUE = 32'hA9B0_0103;

   // Outputs of an APB master
   typedef struct packed {
      logic               sel;
      logic               enable;
      logic               write;
      logic [ADDR_W-1:0]  addr;
      logic [DATA_W-1:0]  wdata;
      logic [WSTRB_W-1:0] wstrb;
   } apb_req_t;

   // APB slave side back to the master
   typedef struct packed {
      logic              ready;  // One-cycle pulse per access
      logic [DATA_W-1:0] rdata;
   } apb_resp_t;

   // IOb master request where a zero strobe marks a read
   typedef struct packed {
      logic               valid;
      logic [ADDR_W-1:0]  addr;
      logic [DATA_W-1:0]  wdata;
      logic [WSTRB_W-1:0] wstrb;
      logic               rready;
   } iob_req_t;

   typedef struct packed {
      logic              ready;
      logic              rvalid;
      logic [DATA_W-1:0] rdata;
   } iob_resp_t;

   // Bridge access sequence
   typedef enum logic [1:0] {
      WAIT_ENABLE    = 2'd0,
      WAIT_READY     = 2'd1,
      RVALID         = 2'd2,
      WAIT_APB_READY = 2'd3
   } bridge_state_t;

endpackage

// ==== hw/apb2iob.sv ====
`timescale 1ns/100ps

module apb2iob (
   input  logic                   clk_i,
   input  logic                   reset_i,
   // APB slave side
   input  apb_iob_pkg::apb_req_t  apb_req_i,
   output apb_iob_pkg::apb_resp_t apb_resp_o,
   // IOb master side
   output apb_iob_pkg::iob_req_t  iob_req_o,
   input  apb_iob_pkg::iob_resp_t iob_resp_i
);

   apb_iob_pkg::bridge_state_t state_q;
   apb_iob_pkg::bridge_state_t state_d;

   logic                           apb_ready_q;
   logic                           apb_ready_d;
   logic [apb_iob_pkg::DATA_W-1:0] apb_rdata_q;
   logic                           iob_valid;
   logic                           iob_rready;

   // Address and data go straight through
   always_comb begin
      iob_req_o.valid  = iob_valid;
      iob_req_o.addr   = apb_req_i.addr;
      iob_req_o.wdata  = apb_req_i.wdata;
      iob_req_o.wstrb  = apb_req_i.write ? apb_req_i.wstrb : '0;  // Zero strobe means read
      iob_req_o.rready = iob_rready;
   end

   // One IOb transaction per APB access phase
   always_comb begin
      state_d     = state_q;
      iob_valid   = 1'b0;
      iob_rready  = 1'b0;
      apb_ready_d = 1'b0;

      case (state_q)
         apb_iob_pkg::WAIT_ENABLE: begin
            if (apb_req_i.sel && apb_req_i.enable) begin
               state_d = apb_iob_pkg::WAIT_READY;
            end
         end
         apb_iob_pkg::WAIT_READY: begin
            iob_valid = 1'b1;  // Held until the slave accepts
            if (iob_resp_i.ready) begin
               if (apb_req_i.write) begin
                  state_d     = apb_iob_pkg::WAIT_APB_READY;
                  apb_ready_d = 1'b1;
               end else begin
                  state_d = apb_iob_pkg::RVALID;
               end
            end
         end
         apb_iob_pkg::RVALID: begin
            iob_rready = 1'b1;
            if (iob_resp_i.rvalid) begin
               state_d     = apb_iob_pkg::WAIT_APB_READY;
               apb_ready_d = 1'b1;
            end
         end
         default: begin
            // APB ready is high here and the master ends its access
            state_d = apb_iob_pkg::WAIT_ENABLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q     <= apb_iob_pkg::WAIT_ENABLE;
         apb_ready_q <= 1'b0;
      end else begin
         state_q     <= state_d;
         apb_ready_q <= apb_ready_d;
      end
   end

   // Read data held until the next read response
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         apb_rdata_q <= '0;
      end else if (iob_resp_i.rvalid && iob_rready) begin
         apb_rdata_q <= iob_resp_i.rdata;
      end
   end

   assign apb_resp_o.ready = apb_ready_q;
   assign apb_resp_o.rdata = apb_rdata_q;

endmodule

// ==== hw/iob_split.sv ====
`timescale 1ns/100ps

module iob_split (
   input  logic                   clk_i,
   input  logic                   reset_i,
   // From the bridge
   input  apb_iob_pkg::iob_req_t  req_i,
   output apb_iob_pkg::iob_resp_t resp_o,
   // Register bank
   output apb_iob_pkg::iob_req_t  reg_req_o,
   input  apb_iob_pkg::iob_resp_t reg_resp_i,
   // Scratch memory
   output apb_iob_pkg::iob_req_t  ram_req_o,
   input  apb_iob_pkg::iob_resp_t ram_resp_i
);

   logic sel_ram;       // Top address bit picks the slave
   logic rd_accept;
   logic pend_q;        // A read response is still owed
   logic pend_ram_q;    // Owner of that response
   logic pend_rvalid;

   assign sel_ram = req_i.addr[apb_iob_pkg::ADDR_W-1];

   always_comb begin
      reg_req_o       = req_i;
      reg_req_o.valid = req_i.valid & ~sel_ram;
      ram_req_o       = req_i;
      ram_req_o.valid = req_i.valid & sel_ram;
   end

   assign rd_accept = req_i.valid && resp_o.ready && (req_i.wstrb == '0);

   // Response comes from the owner of the pending read rather than the current address
   assign pend_rvalid = pend_ram_q ? ram_resp_i.rvalid : reg_resp_i.rvalid;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         pend_q     <= 1'b0;
         pend_ram_q <= 1'b0;
      end else if (rd_accept) begin
         pend_q     <= 1'b1;
         pend_ram_q <= sel_ram;
      end else if (pend_q && pend_rvalid) begin
         pend_q <= 1'b0;
      end
   end

   always_comb begin
      resp_o.ready  = sel_ram ? ram_resp_i.ready : reg_resp_i.ready;
      resp_o.rvalid = pend_q & pend_rvalid;
      resp_o.rdata  = pend_ram_q ? ram_resp_i.rdata : reg_resp_i.rdata;
   end

endmodule

// ==== hw/iob_regbank.sv ====
`timescale 1ns/100ps

module iob_regbank #(
   parameter int N_REGS = 8  // Last index is the identity register
) (
   input  logic                           clk_i,
   input  logic                           reset_i,
   input  apb_iob_pkg::iob_req_t          iob_req_i,
   output apb_iob_pkg::iob_resp_t         iob_resp_o,
   input  logic [apb_iob_pkg::DATA_W-1:0] id_value_i
);

   localparam int IDX_W  = $clog2(N_REGS);
   localparam int WADR_W = apb_iob_pkg::ADDR_W - 2;

   logic [apb_iob_pkg::DATA_W-1:0] regs_q [N_REGS-1];
   logic [WADR_W-1:0]              word_addr;
   logic [IDX_W-1:0]               idx;
   logic                           is_rw_reg;
   logic                           is_id_reg;
   logic                           accept;
   logic                           wr_en;
   logic [apb_iob_pkg::DATA_W-1:0] rd_word;
   logic                           rvalid_q;
   logic [apb_iob_pkg::DATA_W-1:0] rdata_q;

   assign word_addr = iob_req_i.addr[apb_iob_pkg::ADDR_W-1:2];
   assign idx       = word_addr[IDX_W-1:0];
   assign is_rw_reg = (word_addr < WADR_W'(N_REGS - 1));
   assign is_id_reg = (word_addr == WADR_W'(N_REGS - 1));

   // Always ready so a request is accepted in its own cycle
   assign accept = iob_req_i.valid;
   assign wr_en  = accept && (iob_req_i.wstrb != '0) && is_rw_reg;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int r = 0; r < N_REGS - 1; r++) begin
            regs_q[r] <= '0;
         end
      end else if (wr_en) begin
         for (int b = 0; b < apb_iob_pkg::WSTRB_W; b++) begin
            if (iob_req_i.wstrb[b]) begin
               regs_q[idx][b*8 +: 8] <= iob_req_i.wdata[b*8 +: 8];
            end
         end
      end
   end

   // Read decode
   always_comb begin
      rd_word = '0;  // Unmapped words read zero
      if (is_rw_reg) begin
         rd_word = regs_q[idx];
      end else if (is_id_reg) begin
         rd_word = id_value_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= accept && (iob_req_i.wstrb == '0);
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         rdata_q <= rd_word;
      end
   end

   assign iob_resp_o.ready  = iob_req_i.valid;
   assign iob_resp_o.rvalid = rvalid_q;
   assign iob_resp_o.rdata  = rdata_q;

endmodule

// ==== hw/iob_scratch_ram.sv ====
`timescale 1ns/100ps

module iob_scratch_ram #(
   parameter int RAM_DEPTH = 64,  // Words
   parameter int RAM_WAIT  = 2    // Cycles of valid before ready
) (
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  apb_iob_pkg::iob_req_t  iob_req_i,
   output apb_iob_pkg::iob_resp_t iob_resp_o
);

   localparam int AW     = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;
   localparam int CNT_W  = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;
   localparam int WADR_W = apb_iob_pkg::ADDR_W - 2;

   logic [apb_iob_pkg::DATA_W-1:0] mem [RAM_DEPTH];
   logic [CNT_W-1:0]               wait_cnt_q;
   logic                           ready;
   logic                           accept;
   logic [WADR_W-1:0]              word_addr;
   logic [AW-1:0]                  mem_addr;
   logic                           rvalid_q;
   logic [apb_iob_pkg::DATA_W-1:0] rdata_q;

   assign ready  = iob_req_i.valid && (wait_cnt_q == CNT_W'(RAM_WAIT));
   assign accept = ready;

   // Counts cycles of valid until acceptance
   always_ff @(posedge clk_i) begin
      if (reset_i || accept || !iob_req_i.valid) begin
         wait_cnt_q <= '0;
      end else begin
         wait_cnt_q <= wait_cnt_q + 1'b1;
      end
   end

   assign word_addr = iob_req_i.addr[apb_iob_pkg::ADDR_W-1:2];
   assign mem_addr  = AW'(word_addr % WADR_W'(RAM_DEPTH));  // Aliases past the depth

   always_ff @(posedge clk_i) begin
      if (accept) begin
         for (int b = 0; b < apb_iob_pkg::WSTRB_W; b++) begin
            if (iob_req_i.wstrb[b]) begin
               mem[mem_addr][b*8 +: 8] <= iob_req_i.wdata[b*8 +: 8];
            end
         end
         rdata_q <= mem[mem_addr];
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= accept && (iob_req_i.wstrb == '0);  // Reads only
      end
   end

   assign iob_resp_o.ready  = ready;
   assign iob_resp_o.rvalid = rvalid_q;
   assign iob_resp_o.rdata  = rdata_q;

endmodule

// ==== hw/apb_periph_top.sv ====
`timescale 1ns/100ps

module apb_periph_top #(
   parameter int N_REGS    = 8,
   parameter int RAM_DEPTH = 64,
   parameter int RAM_WAIT  = 2
) (
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  apb_iob_pkg::apb_req_t  apb_req_i,
   output apb_iob_pkg::apb_resp_t apb_resp_o
);

   apb_iob_pkg::iob_req_t  bridge_req;
   apb_iob_pkg::iob_resp_t bridge_resp;
   apb_iob_pkg::iob_req_t  reg_req;
   apb_iob_pkg::iob_resp_t reg_resp;
   apb_iob_pkg::iob_req_t  ram_req;
   apb_iob_pkg::iob_resp_t ram_resp;

   apb2iob i_apb2iob (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .apb_req_i  (apb_req_i),
      .apb_resp_o (apb_resp_o),
      .iob_req_o  (bridge_req),
      .iob_resp_i (bridge_resp)
   );

   // Address bit 11 selects the memory
   iob_split i_iob_split (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .req_i      (bridge_req),
      .resp_o     (bridge_resp),
      .reg_req_o  (reg_req),
      .reg_resp_i (reg_resp),
      .ram_req_o  (ram_req),
      .ram_resp_i (ram_resp)
   );

   iob_regbank #(
      .N_REGS (N_REGS)
   ) i_iob_regbank (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .iob_req_i  (reg_req),
      .iob_resp_o (reg_resp),
      .id_value_i (apb_iob_pkg::ID_VALUE)
   );

   iob_scratch_ram #(
      .RAM_DEPTH (RAM_DEPTH),
      .RAM_WAIT  (RAM_WAIT)
   ) i_iob_scratch_ram (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .iob_req_i  (ram_req),
      .iob_resp_o (ram_resp)
   );

endmodule

// ==== testbench/tb_apb_periph.sv ====
`timescale 1ns/100ps

module tb_apb_periph;

   localparam int AW          = apb_iob_pkg::ADDR_W;
   localparam int DW          = apb_iob_pkg::DATA_W;
   localparam int N_REGS      = 8;
   localparam int RAM_DEPTH   = 64;
   localparam int RAM_WAIT    = 2;
   localparam int CLK_PERIOD  = 8;
   localparam int MAX_WAIT    = 50;                       // Cycles allowed for APB ready
   localparam int WATCHDOG_NS = 200 * 10 * CLK_PERIOD;    // 200 accesses of 10 cycles
   localparam logic [AW-1:0] RAM_BASE = 12'h800;          // Top address bit set

   logic                   clk;
   logic                   reset;
   apb_iob_pkg::apb_req_t  apb_req;
   apb_iob_pkg::apb_resp_t apb_resp;

   logic [DW-1:0] reg_model [N_REGS];
   logic [DW-1:0] mem_model [RAM_DEPTH];
   integer        seed = 74;
   int            check_count = 0;
   int            error_count = 0;

   apb_periph_top #(
      .N_REGS    (N_REGS),
      .RAM_DEPTH (RAM_DEPTH),
      .RAM_WAIT  (RAM_WAIT)
   ) i_apb_periph_top (
      .clk_i      (clk),
      .reset_i    (reset),
      .apb_req_i  (apb_req),
      .apb_resp_o (apb_resp)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("FAIL: see errors above");
      $finish;
   end

   task automatic check_value(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                              input string msg);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("FAILED at %0d ns: %s, got %h, expected %h", $time, msg, got, exp);
      end
   endtask

   // Setup and access phases from a falling edge until ready
   task automatic apb_access(input logic write, input logic [AW-1:0] addr,
                             input logic [DW-1:0] wdata, input logic [3:0] wstrb,
                             output logic [DW-1:0] rdata, output int cycles);
      apb_req.sel    = 1'b1;
      apb_req.enable = 1'b0;
      apb_req.write  = write;
      apb_req.addr   = addr;
      apb_req.wdata  = wdata;
      apb_req.wstrb  = wstrb;
      @(negedge clk);
      if (apb_resp.ready) begin
         error_count++;
         $display("APB ready was high in the setup cycle for address %h", addr);
      end
      apb_req.enable = 1'b1;  // Cycle 0 of the access
      cycles = 0;
      rdata  = '0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!apb_resp.ready && cycles < MAX_WAIT);
      if (apb_resp.ready) begin
         rdata = apb_resp.rdata;
      end else begin
         error_count++;
         $display("No APB ready within %0d cycles for address %h", MAX_WAIT, addr);
      end
      apb_req.sel    = 1'b0;
      apb_req.enable = 1'b0;
   endtask

   task automatic apb_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                            input logic [3:0] strb, output int cycles);
      logic [DW-1:0] unused;
      apb_access(1'b1, addr, data, strb, unused, cycles);
   endtask

   task automatic apb_read(input logic [AW-1:0] addr, output logic [DW-1:0] data,
                           output int cycles);
      apb_access(1'b0, addr, '0, 4'h0, data, cycles);
   endtask

   function automatic logic [DW-1:0] rand_word();
      logic [DW-1:0] r;
      r = $random(seed);
      return r;
   endfunction

   function automatic int rand_below(input int n);
      logic [DW-1:0] r;
      r = $random(seed);
      return int'(r[15:0]) % n;
   endfunction

   function automatic logic [AW-1:0] reg_addr(input int idx);
      return AW'(idx * 4);
   endfunction

   function automatic logic [AW-1:0] ram_addr(input int word);
      return RAM_BASE + AW'(word * 4);
   endfunction

   // Byte lanes with strobe set take the new data
   function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old,
                                                 input logic [DW-1:0] data,
                                                 input logic [3:0] strb);
      logic [DW-1:0] res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
      end
      return res;
   endfunction

   function automatic logic [DW-1:0] expected_read(input logic [AW-1:0] addr);
      int word;
      word = int'(addr[AW-2:2]);
      if (addr[AW-1]) return mem_model[word % RAM_DEPTH];
      if (word < N_REGS - 1) return reg_model[word];
      if (word == N_REGS - 1) return apb_iob_pkg::ID_VALUE;
      return '0;  // Unmapped register index
   endfunction

   task automatic write_modeled(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                                input logic [3:0] strb);
      int word;
      int cycles;
      word = int'(addr[AW-2:2]);
      apb_write(addr, data, strb, cycles);
      if (addr[AW-1]) begin
         mem_model[word % RAM_DEPTH] = merge_bytes(mem_model[word % RAM_DEPTH], data, strb);
      end else if (word < N_REGS - 1) begin
         reg_model[word] = merge_bytes(reg_model[word], data, strb);
      end
   endtask

   task automatic read_compare(input logic [AW-1:0] addr);
      logic [DW-1:0] data;
      int            cycles;
      apb_read(addr, data, cycles);
      check_value(data, expected_read(addr), $sformatf("read of address %h", addr));
   endtask

   task automatic test_done(input string name, input int errors_before);
      $display("%s finished with %0d errors", name, error_count - errors_before);
   endtask

   task automatic reset_values();
      int e0;
      e0 = error_count;
      for (int i = 0; i <= N_REGS; i++) read_compare(reg_addr(i));
      test_done("reset values", e0);
   endtask

   task automatic full_word_writes();
      int e0;
      e0 = error_count;
      for (int i = 0; i < N_REGS; i++) write_modeled(reg_addr(i), rand_word(), 4'hF);
      for (int i = 0; i < N_REGS; i++) read_compare(reg_addr(i));
      test_done("full word writes", e0);
   endtask

   task automatic partial_strobes();
      logic [3:0]    strb;
      logic [DW-1:0] r;
      int            e0;
      int            idx;
      e0 = error_count;
      for (int n = 0; n < 16; n++) begin
         idx  = rand_below(N_REGS - 1);
         r    = rand_word();
         strb = r[3:0];
         if (strb == 4'h0) strb = 4'h1;  // Zero strobe would be a read on IOb
         write_modeled(reg_addr(idx), rand_word(), strb);
         read_compare(reg_addr(idx));
      end
      test_done("partial strobes", e0);
   endtask

   task automatic memory_round_trip();
      int words[$];
      int e0;
      int w;
      e0 = error_count;
      for (int n = 0; n < 16; n++) begin
         w = rand_below(RAM_DEPTH);
         words.push_back(w);
         write_modeled(ram_addr(w), rand_word(), 4'hF);
      end
      foreach (words[i]) read_compare(ram_addr(words[i]));
      w = rand_below(RAM_DEPTH);
      write_modeled(ram_addr(w + RAM_DEPTH), rand_word(), 4'hF);  // Wraps to word w
      read_compare(ram_addr(w));
      test_done("memory round trip", e0);
   endtask

   task automatic access_latency();
      logic [DW-1:0] data;
      int            cycles;
      int            e0;
      e0 = error_count;
      apb_write(reg_addr(1), 32'h1234_5678, 4'hF, cycles);
      reg_model[1] = 32'h1234_5678;
      check_value(DW'(cycles), DW'(2), "register write latency");
      apb_read(reg_addr(1), data, cycles);
      check_value(DW'(cycles), DW'(3), "register read latency");
      check_value(data, expected_read(reg_addr(1)), "register read data");
      apb_write(ram_addr(5), 32'hCAFE_0005, 4'hF, cycles);
      mem_model[5] = 32'hCAFE_0005;
      check_value(DW'(cycles), DW'(2 + RAM_WAIT), "memory write latency");
      apb_read(ram_addr(5), data, cycles);
      check_value(DW'(cycles), DW'(3 + RAM_WAIT), "memory read latency");
      check_value(data, expected_read(ram_addr(5)), "memory read data");
      test_done("access latency", e0);
   endtask

   task automatic interleaved_slaves();
      int e0;
      int idx;
      int w;
      e0 = error_count;
      for (int n = 0; n < 8; n++) begin
         idx = rand_below(N_REGS - 1);
         w   = rand_below(RAM_DEPTH);
         write_modeled(reg_addr(idx), rand_word(), 4'hF);
         write_modeled(ram_addr(w), rand_word(), 4'hF);
         read_compare(reg_addr(idx));
         read_compare(ram_addr(w));
      end
      test_done("interleaved slaves", e0);
   endtask

   initial begin
      apb_req = '0;
      reset   = 1'b1;
      for (int i = 0; i < N_REGS; i++) reg_model[i] = '0;
      for (int i = 0; i < RAM_DEPTH; i++) mem_model[i] = '0;
      repeat (2) @(negedge clk);
      reset = 1'b0;
      reset_values();
      full_word_writes();
      partial_strobes();
      memory_round_trip();
      access_latency();
      interleaved_slaves();
      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
hw/apb_iob_pkg.sv
hw/apb2iob.sv
hw/iob_split.sv
hw/iob_regbank.sv
hw/iob_scratch_ram.sv
hw/apb_periph_top.sv
testbench/tb_apb_periph.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the APB peripheral testbench with Verilator

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_apb_periph -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
   echo "Simulation reported failures"
   exit 1
fi

exit 0
